//--- mouse_vga_params.svh
`ifndef MOUSE_VGA_PARAMS_SVH
`define MOUSE_VGA_PARAMS_SVH

// 640x480 at 60 Hz, counted in pixel slots
`define H_ACTIVE 640
`define H_FRONT 16
`define H_SYNC 96
`define H_TOTAL 800
`define V_ACTIVE 480
`define V_FRONT 10
`define V_SYNC 2
`define V_TOTAL 525

`define CURSOR_SIZE 8
`define CURSOR_X0 320
`define CURSOR_Y0 240

`define COLOR_BG 12'h003
`define COLOR_CURSOR 12'hFFF
`define COLOR_CLICK 12'hF00

// switch codes for the LED mux
`define LED_SEL_STATUS 0
`define LED_SEL_DX 1
`define LED_SEL_DY 2
`define LED_SEL_COUNT 3

`endif

//--- mouse_vga_pkg.sv
package mouse_vga_pkg;

	// pixel currently being scanned by the timing generator
	typedef struct packed {
		logic [9:0] x;
		logic [9:0] y;
		logic       active;
	} pixel_pos_t;

	// three-byte movement packet as sent by the mouse
	typedef struct packed {
		logic [7:0] status;
		logic [7:0] dx;
		logic [7:0] dy;
	} mouse_packet_t;

	typedef struct packed {
		logic [9:0] x;
		logic [9:0] y;
	} cursor_t;

	typedef struct packed {
		logic [3:0] r;
		logic [3:0] g;
		logic [3:0] b;
	} rgb_t;

	typedef enum logic [1:0] {
		PS2_IDLE,
		PS2_DATA,
		PS2_PARITY,
		PS2_STOP
	} ps2_state_t;

	typedef enum logic [1:0] {
		ASM_BYTE0,
		ASM_BYTE1,
		ASM_BYTE2
	} asm_state_t;

endpackage

//--- vga_timing.sv
`timescale 1ns/1ps
`include "mouse_vga_params.svh"

module vga_timing
	import mouse_vga_pkg::*;
(
	input  logic       CLK_50M,
	input  logic       rst,
	output logic       pixel_en,
	output pixel_pos_t pos,
	output logic       hsync,
	output logic       vsync
);

	logic [9:0] h_cnt;
	logic [9:0] v_cnt;

	// 25 MHz pixel rate as an enable on every second cycle
	always_ff @(posedge CLK_50M) begin
		if (rst) begin
			pixel_en <= 1'b0;
		end else begin
			pixel_en <= ~pixel_en;
		end
	end

	always_ff @(posedge CLK_50M) begin
		if (rst) begin
			h_cnt <= '0;
			v_cnt <= '0;
		end else if (pixel_en) begin
			if (h_cnt == 10'(`H_TOTAL - 1)) begin
				h_cnt <= '0;
				if (v_cnt == 10'(`V_TOTAL - 1)) begin
					v_cnt <= '0;
				end else begin
					v_cnt <= v_cnt + 10'd1;
				end
			end else begin
				h_cnt <= h_cnt + 10'd1;
			end
		end
	end

	// position and syncs are registered from the same count so they stay aligned
	always_ff @(posedge CLK_50M) begin
		if (rst) begin
			pos   <= '0;
			hsync <= 1'b1;
			vsync <= 1'b1;
		end else if (pixel_en) begin
			pos.x      <= h_cnt;
			pos.y      <= v_cnt;
			pos.active <= (h_cnt < 10'(`H_ACTIVE)) && (v_cnt < 10'(`V_ACTIVE));
			hsync      <= !((h_cnt >= 10'(`H_ACTIVE + `H_FRONT)) &&
				(h_cnt < 10'(`H_ACTIVE + `H_FRONT + `H_SYNC)));
			vsync      <= !((v_cnt >= 10'(`V_ACTIVE + `V_FRONT)) &&
				(v_cnt < 10'(`V_ACTIVE + `V_FRONT + `V_SYNC)));
		end
	end

endmodule

//--- ps2_receiver.sv
`timescale 1ns/1ps

module ps2_receiver
	import mouse_vga_pkg::*;
(
	input  logic       CLK_50M,
	input  logic       rst,
	input  logic       ps2_clk,
	input  logic       ps2_data,
	output logic [7:0] byte_data,
	output logic       byte_valid,
	output logic       frame_error
);

	logic [1:0] clk_sync;
	logic [1:0] data_sync;
	logic       clk_prev;
	logic       clk_fall;
	logic       bit_in;
	ps2_state_t state;
	logic [2:0] bit_cnt;
	logic [7:0] shift_reg;
	logic       parity_ok;

	// both lines come from the mouse asynchronously
	always_ff @(posedge CLK_50M) begin
		if (rst) begin
			clk_sync  <= 2'b11;
			data_sync <= 2'b11;
			clk_prev  <= 1'b1;
		end else begin
			clk_sync  <= {clk_sync[0], ps2_clk};
			data_sync <= {data_sync[0], ps2_data};
			clk_prev  <= clk_sync[1];
		end
	end

	assign clk_fall = clk_prev & ~clk_sync[1];
	assign bit_in   = data_sync[1];

	always_ff @(posedge CLK_50M) begin
		if (rst) begin
			state       <= PS2_IDLE;
			bit_cnt     <= '0;
			parity_ok   <= 1'b0;
			byte_valid  <= 1'b0;
			frame_error <= 1'b0;
		end else begin
			byte_valid  <= 1'b0;
			frame_error <= 1'b0;
			if (clk_fall) begin
				case (state)
					PS2_IDLE: begin
						bit_cnt <= '0;
						if (!bit_in) begin
							state <= PS2_DATA;
						end else begin
							frame_error <= 1'b1;
						end
					end
					PS2_DATA: begin
						// data arrives LSB first
						shift_reg <= {bit_in, shift_reg[7:1]};
						bit_cnt   <= bit_cnt + 3'd1;
						if (bit_cnt == 3'd7) begin
							state <= PS2_PARITY;
						end
					end
					PS2_PARITY: begin
						// odd parity over data plus parity bit
						parity_ok <= (^shift_reg) ^ bit_in;
						state     <= PS2_STOP;
					end
					PS2_STOP: begin
						if (bit_in && parity_ok) begin
							byte_data  <= shift_reg;
							byte_valid <= 1'b1;
						end else begin
							frame_error <= 1'b1;
						end
						state <= PS2_IDLE;
					end
					default: state <= PS2_IDLE;
				endcase
			end
		end
	end

endmodule

//--- mouse_packet_assembler.sv
`timescale 1ns/1ps

module mouse_packet_assembler
	import mouse_vga_pkg::*;
(
	input  logic          CLK_50M,
	input  logic          rst,
	input  logic [7:0]    byte_data,
	input  logic          byte_valid,
	input  logic          frame_error,
	output mouse_packet_t packet,
	output logic          packet_valid,
	output logic [7:0]    packet_count
);

	asm_state_t state;
	logic [7:0] status_r;
	logic [7:0] dx_r;

	always_ff @(posedge CLK_50M) begin
		if (rst) begin
			state        <= ASM_BYTE0;
			packet_valid <= 1'b0;
			packet_count <= '0;
		end else begin
			packet_valid <= 1'b0;
			if (frame_error) begin
				// a lost byte breaks the packet, start over
				state <= ASM_BYTE0;
			end else if (byte_valid) begin
				case (state)
					ASM_BYTE0: begin
						// bit 3 of the status byte is always one
						if (byte_data[3]) begin
							status_r <= byte_data;
							state    <= ASM_BYTE1;
						end
					end
					ASM_BYTE1: begin
						dx_r  <= byte_data;
						state <= ASM_BYTE2;
					end
					ASM_BYTE2: begin
						packet.status <= status_r;
						packet.dx     <= dx_r;
						packet.dy     <= byte_data;
						packet_valid  <= 1'b1;
						packet_count  <= packet_count + 8'd1;
						state         <= ASM_BYTE0;
					end
					default: state <= ASM_BYTE0;
				endcase
			end
		end
	end

endmodule

//--- cursor_tracker.sv
`timescale 1ns/1ps
`include "mouse_vga_params.svh"

module cursor_tracker
	import mouse_vga_pkg::*;
(
	input  logic          CLK_50M,
	input  logic          rst,
	input  mouse_packet_t packet,
	input  logic          packet_valid,
	output cursor_t       cursor,
	output logic          left_button
);

	logic        [8:0]  dx9;
	logic        [8:0]  dy9;
	logic signed [11:0] sum_x;
	logic signed [11:0] sum_y;
	logic        [9:0]  next_x;
	logic        [9:0]  next_y;

	always_comb begin
		// sign bits live in the status byte, overflowed deltas are dropped
		dx9 = packet.status[6] ? 9'd0 : {packet.status[4], packet.dx};
		dy9 = packet.status[7] ? 9'd0 : {packet.status[5], packet.dy};
		sum_x = $signed({2'b00, cursor.x}) + $signed({{3{dx9[8]}}, dx9});
		// screen y grows downward while mouse y grows upward
		sum_y = $signed({2'b00, cursor.y}) - $signed({{3{dy9[8]}}, dy9});

		if (sum_x < 0) begin
			next_x = '0;
		end else if (sum_x > 12'sd`H_ACTIVE - 12'sd1) begin
			next_x = 10'(`H_ACTIVE - 1);
		end else begin
			next_x = sum_x[9:0];
		end

		if (sum_y < 0) begin
			next_y = '0;
		end else if (sum_y > 12'sd`V_ACTIVE - 12'sd1) begin
			next_y = 10'(`V_ACTIVE - 1);
		end else begin
			next_y = sum_y[9:0];
		end
	end

	always_ff @(posedge CLK_50M) begin
		if (rst) begin
			cursor.x    <= 10'(`CURSOR_X0);
			cursor.y    <= 10'(`CURSOR_Y0);
			left_button <= 1'b0;
		end else if (packet_valid) begin
			cursor.x    <= next_x;
			cursor.y    <= next_y;
			left_button <= packet.status[0];
		end
	end

endmodule

//--- cursor_renderer.sv
`timescale 1ns/1ps
`include "mouse_vga_params.svh"

module cursor_renderer
	import mouse_vga_pkg::*;
(
	input  logic       CLK_50M,
	input  logic       rst,
	input  logic       pixel_en,
	input  pixel_pos_t pos,
	input  logic       hsync,
	input  logic       vsync,
	input  cursor_t    cursor,
	input  logic       left_button,
	output rgb_t       rgb,
	output logic       hsync_out,
	output logic       vsync_out
);

	logic in_cursor;
	rgb_t pixel_color;

	// one bit wider so the box edge near the screen border does not wrap
	assign in_cursor = ({1'b0, pos.x} >= {1'b0, cursor.x}) &&
		({1'b0, pos.x} < {1'b0, cursor.x} + 11'(`CURSOR_SIZE)) &&
		({1'b0, pos.y} >= {1'b0, cursor.y}) &&
		({1'b0, pos.y} < {1'b0, cursor.y} + 11'(`CURSOR_SIZE));

	always_comb begin
		if (!pos.active) begin
			pixel_color = '0;
		end else if (in_cursor) begin
			pixel_color = left_button ? rgb_t'(`COLOR_CLICK) : rgb_t'(`COLOR_CURSOR);
		end else begin
			pixel_color = rgb_t'(`COLOR_BG);
		end
	end

	// syncs take the same register stage as the color
	always_ff @(posedge CLK_50M) begin
		if (rst) begin
			rgb       <= '0;
			hsync_out <= 1'b1;
			vsync_out <= 1'b1;
		end else if (pixel_en) begin
			rgb       <= pixel_color;
			hsync_out <= hsync;
			vsync_out <= vsync;
		end
	end

endmodule

//--- mouse_vga_top.sv
`timescale 1ns/1ps
`include "mouse_vga_params.svh"

module mouse_vga_top
	import mouse_vga_pkg::*;
(
	input  logic       CLK_50M,
	input  logic       rst,
	input  logic       PS2_CLK,
	input  logic       PS2_DATA,
	input  logic [2:0] SW,
	output logic [7:0] LED,
	output logic [3:0] VGA_R,
	output logic [3:0] VGA_G,
	output logic [3:0] VGA_B,
	output logic       VGA_HSYNC,
	output logic       VGA_VSYNC
);

	logic [7:0]    byte_data;
	logic          byte_valid;
	logic          frame_error;
	mouse_packet_t packet;
	logic          packet_valid;
	logic [7:0]    packet_count;
	mouse_packet_t last_packet;
	cursor_t       cursor;
	logic          left_button;
	logic          pixel_en;
	pixel_pos_t    pos;
	logic          hsync;
	logic          vsync;
	rgb_t          rgb;

	ps2_receiver ps2_receiver_i (
		.CLK_50M     (CLK_50M),
		.rst         (rst),
		.ps2_clk     (PS2_CLK),
		.ps2_data    (PS2_DATA),
		.byte_data   (byte_data),
		.byte_valid  (byte_valid),
		.frame_error (frame_error)
	);

	mouse_packet_assembler mouse_packet_assembler_i (
		.CLK_50M      (CLK_50M),
		.rst          (rst),
		.byte_data    (byte_data),
		.byte_valid   (byte_valid),
		.frame_error  (frame_error),
		.packet       (packet),
		.packet_valid (packet_valid),
		.packet_count (packet_count)
	);

	cursor_tracker cursor_tracker_i (
		.CLK_50M      (CLK_50M),
		.rst          (rst),
		.packet       (packet),
		.packet_valid (packet_valid),
		.cursor       (cursor),
		.left_button  (left_button)
	);

	vga_timing vga_timing_i (
		.CLK_50M  (CLK_50M),
		.rst      (rst),
		.pixel_en (pixel_en),
		.pos      (pos),
		.hsync    (hsync),
		.vsync    (vsync)
	);

	cursor_renderer cursor_renderer_i (
		.CLK_50M     (CLK_50M),
		.rst         (rst),
		.pixel_en    (pixel_en),
		.pos         (pos),
		.hsync       (hsync),
		.vsync       (vsync),
		.cursor      (cursor),
		.left_button (left_button),
		.rgb         (rgb),
		.hsync_out   (VGA_HSYNC),
		.vsync_out   (VGA_VSYNC)
	);

	assign VGA_R = rgb.r;
	assign VGA_G = rgb.g;
	assign VGA_B = rgb.b;

	// keep the last packet for the LEDs
	always_ff @(posedge CLK_50M) begin
		if (rst) begin
			last_packet <= '0;
		end else if (packet_valid) begin
			last_packet <= packet;
		end
	end

	always_ff @(posedge CLK_50M) begin
		if (rst) begin
			LED <= '0;
		end else begin
			case (SW)
				3'(`LED_SEL_STATUS): LED <= last_packet.status;
				3'(`LED_SEL_DX):     LED <= last_packet.dx;
				3'(`LED_SEL_DY):     LED <= last_packet.dy;
				3'(`LED_SEL_COUNT):  LED <= packet_count;
				default:             LED <= '0;
			endcase
		end
	end

endmodule

//--- mouse_vga_sva.sv
`timescale 1ns/1ps

module mouse_vga_sva (
	input logic CLK_50M,
	input logic rst,
	input logic byte_valid,
	input logic frame_error,
	input logic pixel_en,
	input logic hsync
);

	// a received frame ends in exactly one kind of strobe
	strobe_exclusive: assert property (@(posedge CLK_50M) disable iff (rst)
		!(byte_valid && frame_error))
		else $error("byte_valid and frame_error high in the same cycle");

	pixel_en_toggles: assert property (@(posedge CLK_50M) disable iff (rst)
		!$past(rst) |-> (pixel_en != $past(pixel_en)))
		else $error("pixel_en did not alternate");

	// hsync is registered only on pixel enable cycles
	hsync_on_pixel_en: assert property (@(posedge CLK_50M) disable iff (rst)
		(!$past(rst) && !$past(pixel_en)) |-> $stable(hsync))
		else $error("hsync changed without a pixel enable");

endmodule

bind mouse_vga_top mouse_vga_sva mouse_vga_sva_i (
	.CLK_50M     (CLK_50M),
	.rst         (rst),
	.byte_valid  (byte_valid),
	.frame_error (frame_error),
	.pixel_en    (pixel_en),
	.hsync       (hsync)
);

//--- mouse_vga_tb.sv
`timescale 1ns/1ps
`include "mouse_vga_params.svh"

module mouse_vga_tb
	import mouse_vga_pkg::*;
();

	// one frame in ns, and one PS/2 byte with its idle gap
	localparam int FRAME_NS = 2 * `H_TOTAL * `V_TOTAL * 20;
	localparam int PS2_BYTE_NS = 12 * 4000;
	localparam int WATCHDOG_NS = 4 * FRAME_NS + 256 * PS2_BYTE_NS;

	logic       CLK_50M;
	logic       rst;
	logic       PS2_CLK;
	logic       PS2_DATA;
	logic [2:0] SW;
	logic [7:0] LED;
	logic [3:0] VGA_R;
	logic [3:0] VGA_G;
	logic [3:0] VGA_B;
	logic       VGA_HSYNC;
	logic       VGA_VSYNC;

	int            errors;
	int            checks;
	mouse_packet_t exp_pkt;
	int            exp_count;
	int            exp_x;
	int            exp_y;
	rgb_t          rgb_hist [0:2047];
	rgb_t          line_rgb [0:639];
	int            cyc;
	int            cur_line;
	int            want_line;
	int            cap_x;
	logic          hsync_prev;
	logic          vsync_prev;
	event          line_captured;

	mouse_vga_top mouse_vga_top_i (
		.CLK_50M   (CLK_50M),
		.rst       (rst),
		.PS2_CLK   (PS2_CLK),
		.PS2_DATA  (PS2_DATA),
		.SW        (SW),
		.LED       (LED),
		.VGA_R     (VGA_R),
		.VGA_G     (VGA_G),
		.VGA_B     (VGA_B),
		.VGA_HSYNC (VGA_HSYNC),
		.VGA_VSYNC (VGA_VSYNC)
	);

	initial begin
		CLK_50M = 1'b0;
		forever #10 CLK_50M = ~CLK_50M;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired: the tests did not finish within %0d ns", WATCHDOG_NS);
		$display("RESULT: FAIL");
		$finish;
	end

	// screen sampler, keeps a history of rgb and counts lines from the syncs
	initial begin
		cyc = 0;
		cur_line = 0;
		hsync_prev = 1'b1;
		vsync_prev = 1'b1;
		forever begin
			@(posedge CLK_50M);
			#1;
			cyc = cyc + 1;
			rgb_hist[cyc % 2048] = {VGA_R, VGA_G, VGA_B};
			if (rst) begin
				cur_line = 0;
			end else begin
				if (vsync_prev && !VGA_VSYNC) begin
					cur_line = `V_ACTIVE + `V_FRONT;
				end
				if (hsync_prev && !VGA_HSYNC) begin
					// hsync falls in the slot of pixel 656, each slot is two clocks
					if (cur_line == want_line) begin
						for (cap_x = 0; cap_x < `H_ACTIVE; cap_x++) begin
							line_rgb[cap_x] =
								rgb_hist[(cyc - 2 * (`H_ACTIVE + `H_FRONT - cap_x)) % 2048];
						end
						-> line_captured;
					end
					cur_line = (cur_line + 1) % `V_TOTAL;
				end
			end
			hsync_prev = VGA_HSYNC;
			vsync_prev = VGA_VSYNC;
		end
	end

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge CLK_50M);
		#2;
	endtask

	task automatic check_led(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_rgb(input string name, input rgb_t got, input rgb_t exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_count(input string name, input int got, input int exp);
		checks++;
		if (got != exp) begin
			errors++;
			$display("** Error: %s = 0x%h cycles, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_level(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	function automatic int limit_range(input int v, input int lo, input int hi);
		return (v < lo) ? lo : ((v > hi) ? hi : v);
	endfunction

	function automatic logic sync_level(input logic vertical);
		return vertical ? VGA_VSYNC : VGA_HSYNC;
	endfunction

	task automatic apply_reset();
		rst = 1'b1;
		wait_cycles(3);
		rst = 1'b0;
		exp_pkt = '0;
		exp_count = 0;
		exp_x = `CURSOR_X0;
		exp_y = `CURSOR_Y0;
	endtask

	// frame is start, eight data bits LSB first, odd parity, stop
	task automatic send_ps2_byte(input logic [7:0] data, input logic bad_parity);
		logic [10:0] frame;
		int i;
		frame = {1'b1, ~(^data) ^ bad_parity, data, 1'b0};
		for (i = 0; i < 11; i++) begin
			PS2_DATA = frame[i];
			wait_cycles(50);
			PS2_CLK = 1'b0;
			wait_cycles(100);
			PS2_CLK = 1'b1;
			wait_cycles(50);
		end
		PS2_DATA = 1'b1;
		wait_cycles(200);
	endtask

	// expected cursor and LED state after a complete packet
	task automatic model_packet(input logic [7:0] status, input logic [7:0] dx,
			input logic [7:0] dy);
		int mx;
		int my;
		mx = status[6] ? 0 : (status[4] ? int'(dx) - 256 : int'(dx));
		my = status[7] ? 0 : (status[5] ? int'(dy) - 256 : int'(dy));
		exp_x = limit_range(exp_x + mx, 0, `H_ACTIVE - 1);
		exp_y = limit_range(exp_y - my, 0, `V_ACTIVE - 1);
		exp_pkt = {status, dx, dy};
		exp_count = (exp_count + 1) % 256;
	endtask

	task automatic send_packet(input logic [7:0] status, input logic [7:0] dx,
			input logic [7:0] dy);
		send_ps2_byte(status, 1'b0);
		send_ps2_byte(dx, 1'b0);
		send_ps2_byte(dy, 1'b0);
		model_packet(status, dx, dy);
	endtask

	task automatic read_led(input int sel, output logic [7:0] led);
		SW = 3'(sel);
		wait_cycles(2);
		led = LED;
	endtask

	task automatic check_led_fields();
		logic [7:0] led;
		read_led(`LED_SEL_STATUS, led);
		check_led("LED (SW status)", led, exp_pkt.status);
		read_led(`LED_SEL_DX, led);
		check_led("LED (SW dx)", led, exp_pkt.dx);
		read_led(`LED_SEL_DY, led);
		check_led("LED (SW dy)", led, exp_pkt.dy);
		read_led(`LED_SEL_COUNT, led);
		check_led("LED (SW count)", led, 8'(exp_count));
	endtask

	task automatic time_sync(input logic vertical, input logic with_period,
			output int low_cycles, output int period_cycles);
		logic prev;
		int n;
		prev = 1'b0;
		while (!(prev && !sync_level(vertical))) begin
			prev = sync_level(vertical);
			wait_cycles(1);
		end
		n = 0;
		while (!sync_level(vertical)) begin
			n++;
			wait_cycles(1);
		end
		low_cycles = n;
		if (with_period) begin
			while (sync_level(vertical)) begin
				n++;
				wait_cycles(1);
			end
		end
		period_cycles = n;
	endtask

	task automatic sample_line(input int y);
		want_line = y;
		@(line_captured);
		want_line = -1;
		wait_cycles(1);
	endtask

	task automatic test_reset_values();
		logic [7:0] led;
		int sel;
		check_level("VGA_HSYNC", VGA_HSYNC, 1'b1);
		check_level("VGA_VSYNC", VGA_VSYNC, 1'b1);
		for (sel = 0; sel < 8; sel++) begin
			read_led(sel, led);
			check_led($sformatf("LED (SW %0d)", sel), led, 8'h00);
		end
	endtask

	task automatic test_vga_timing();
		int low;
		int period;
		time_sync(1'b0, 1'b1, low, period);
		check_count("VGA_HSYNC low", low, 2 * `H_SYNC);
		check_count("VGA_HSYNC period", period, 2 * `H_TOTAL);
		time_sync(1'b1, 1'b0, low, period);
		check_count("VGA_VSYNC low", low, 2 * `H_TOTAL * `V_SYNC);
	endtask

	task automatic test_packet_fields();
		logic [7:0] dx;
		logic [7:0] dy;
		dx = 8'($urandom_range(1, 30));
		dy = 8'($urandom_range(1, 30));
		send_packet(8'h08, dx, dy);
		check_led_fields();
		// without bit 3 the byte cannot start a packet
		send_ps2_byte(8'h02, 1'b0);
		send_packet(8'h08, dy, dx);
		check_led_fields();
	endtask

	task automatic test_parity_error();
		logic [7:0] led;
		send_ps2_byte(8'h08, 1'b0);
		send_ps2_byte(8'h05, 1'b0);
		send_ps2_byte(8'h07, 1'b1);
		read_led(`LED_SEL_COUNT, led);
		check_led("LED (SW count)", led, 8'(exp_count));
		send_packet(8'h08, 8'h03, 8'h02);
		check_led_fields();
	endtask

	task automatic test_cursor_draw();
		apply_reset();
		send_packet(8'h08, 8'd16, 8'd8);
		sample_line(exp_y);
		check_rgb($sformatf("VGA rgb at (%0d,%0d)", exp_x, exp_y), line_rgb[exp_x],
			rgb_t'(`COLOR_CURSOR));
		check_rgb($sformatf("VGA rgb at (%0d,%0d)", exp_x - 1, exp_y), line_rgb[exp_x - 1],
			rgb_t'(`COLOR_BG));
		send_packet(8'h09, 8'h00, 8'h00);
		sample_line(exp_y);
		check_rgb($sformatf("VGA rgb at (%0d,%0d)", exp_x, exp_y), line_rgb[exp_x],
			rgb_t'(`COLOR_CLICK));
	endtask

	task automatic test_clamp_overflow();
		repeat (3) send_packet(8'h18, 8'h80, 8'h00);
		// x overflow set, so the large dx must be ignored
		send_packet(8'h48, 8'h40, 8'h00);
		sample_line(exp_y);
		check_rgb($sformatf("VGA rgb at (%0d,%0d)", exp_x, exp_y), line_rgb[exp_x],
			rgb_t'(`COLOR_CURSOR));
		check_rgb($sformatf("VGA rgb at (%0d,%0d)", exp_x + `CURSOR_SIZE, exp_y),
			line_rgb[exp_x + `CURSOR_SIZE], rgb_t'(`COLOR_BG));
	endtask

	initial begin
		void'($urandom(18));
		errors = 0;
		checks = 0;
		want_line = -1;
		rst = 1'b1;
		PS2_CLK = 1'b1;
		PS2_DATA = 1'b1;
		SW = 3'd0;
		apply_reset();
		test_reset_values();
		test_vga_timing();
		test_packet_fields();
		test_parity_error();
		test_cursor_draw();
		test_clamp_overflow();
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

//--- mouse_vga_top.f
+incdir+.
mouse_vga_pkg.sv
vga_timing.sv
ps2_receiver.sv
mouse_packet_assembler.sv
cursor_tracker.sv
cursor_renderer.sv
mouse_vga_top.sv
mouse_vga_sva.sv
mouse_vga_tb.sv

//--- Makefile
.PHONY: help test clean

LOG := sim.log

help:
	@echo "make test   build with Verilator and run the testbench"
	@echo "make clean  remove the build folder and the log"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module mouse_vga_tb -Mdir obj_dir -f mouse_vga_top.f
	./obj_dir/Vmouse_vga_tb | tee $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then \
		echo "simulation reported a failure"; exit 1; \
	fi
	@if ! grep -q "RESULT: PASS" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
